// ==== testbench/endpoint_tests.txt ====
// group port w eva data tgo_x tgo_y dram kind(1 packet, 0 error) exp_x exp_y exp_epa
// all hex, a group value of ff ends the list
00 0 0 420C0123 00000000 0 0 1 1 3 2 00123
01 1 1 21080456 DEADBEEF 1 2 1 1 3 3 00456
02 2 1 263BFFFF 0000A5A5 5 3 1 1 3 1 3FFFF
03 0 0 08000ACC 00000000 1 2 1 1 3 3 0102B
04 1 1 80000A74 12345678 0 0 1 1 1 0 00055
05 2 0 800001C8 00000000 0 0 1 1 3 7 0000A
06 0 1 80007EBC CAFEF00D 0 0 1 1 3 0 001F7
07 1 0 C0012344 00000000 0 0 0 1 0 1 248D1
08 2 1 C00FFFFC 55AA55AA 0 0 0 1 0 1 3FFFF
09 0 0 80006554 00000000 0 0 0 1 2 7 00155
0a 1 1 80001FFC 0F0F0F0F 0 0 0 1 1 0 003FF
0b 2 0 01234567 00000000 0 0 1 0 0 0 00000
0c 0 1 4507FFFC 11111111 2 1 1 1 1 5 3FFFC
0c 1 0 080201FC 22222222 2 1 1 1 5 4 01807
0c 2 1 20000ABC 33333333 2 1 1 1 2 1 00ABC
0d 0 0 00000000 00000000 0 0 1 0 0 0 00000
0d 1 1 7FFC0001 44444444 0 0 1 1 F 7 00001
0d 2 0 80000000 00000000 0 0 1 1 0 0 00000
0e 0 1 0FFFFE00 66666666 4 5 0 1 4 5 00FF8
0f 1 0 04000000 00000000 0 0 1 0 0 0 00000
0f 2 1 40000000 77777777 0 0 1 1 0 0 00000
ff 0 0 00000000 00000000 0 0 0 0 0 0 00000

// ==== files.f ====
hw/manycore_addr_pkg.sv
hw/manycore_net_pkg.sv
hw/vcache_bank_hash.sv
hw/eva_to_npa.sv
hw/endpoint_req_port.sv
hw/net_inject_arbiter.sv
hw/manycore_endpoint_top.sv
testbench/endpoint_assertions.sv
testbench/tb_endpoint_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_endpoint_top
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
TESTS     := testbench/endpoint_tests.txt
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(TESTS)
	./$(SIM) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation FAILED, no pass line"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_endpoint_top.sv ====
`timescale 1ns/1ps

module tb_endpoint_top
  import manycore_addr_pkg::*;
  import manycore_net_pkg::*;
();

  localparam int num_ports_lp    = 3;
  localparam int fields_lp       = 12;  // hex words per test line
  localparam int max_lines_lp    = 64;
  localparam int reset_cycles_lp = 16;
  localparam int col_group_lp    = 0;
  localparam int col_port_lp     = 1;
  localparam int col_w_lp        = 2;
  localparam int col_eva_lp      = 3;
  localparam int col_data_lp     = 4;
  localparam int col_tgo_x_lp    = 5;
  localparam int col_tgo_y_lp    = 6;
  localparam int col_dram_lp     = 7;
  localparam int col_kind_lp     = 8;
  localparam int col_x_lp        = 9;
  localparam int col_y_lp        = 10;
  localparam int col_epa_lp      = 11;

  typedef struct packed {
    logic                       w;
    logic [data_width_gp-1:0]   data;
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0]    epa;
  } exp_pkt_s;

  logic                       clk;
  logic                       rst_n;
  req_s [num_ports_lp-1:0]    req;
  logic [x_cord_width_gp-1:0] tgo_x;
  logic [y_cord_width_gp-1:0] tgo_y;
  logic                       dram_enable;
  logic [num_ports_lp-1:0]    busy;
  logic [num_ports_lp-1:0]    err;
  logic                       pkt_v;
  net_packet_s                pkt;

  logic [31:0] test_mem [0:max_lines_lp*fields_lp-1];
  int          num_lines;
  int          timeout_cycles = 0;
  int          cycle_cnt = 0;
  int          rr_ptr;                      // model of the arbiter pointer
  exp_pkt_s    exp_q [num_ports_lp][$];     // packets still owed, per port
  int          err_exp [num_ports_lp];
  int          strobe_cycle [num_ports_lp];
  int          pkt_lines [num_ports_lp];    // packet requests in that port's last group

  manycore_endpoint_top #(
    .num_ports_p                 (num_ports_lp),
    .num_tiles_x_p               (4),
    .vcache_block_size_in_words_p(8),
    .vcache_sets_p               (64),
    .vcache_size_p               (1024)
  ) dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (req),
    .tgo_x_i      (tgo_x),
    .tgo_y_i      (tgo_y),
    .dram_enable_i(dram_enable),
    .busy_o       (busy),
    .err_o        (err),
    .pkt_v_o      (pkt_v),
    .pkt_o        (pkt)
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic fail_and_stop();
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic abort_run(input string reason);
    $display("ERROR at %0t: %s", $time, reason);
    fail_and_stop();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t %s actual=0x%0h expected=0x%0h",
               $time, name, actual, expected);
      fail_and_stop();
    end
  endtask

  function automatic logic [31:0] test_field(input int line, input int col);
    return test_mem[line*fields_lp + col];
  endfunction

  // strobe every line of one group together, then wait for all ports idle
  task automatic run_group(input int first, input int last);
    int          port;
    int          n_pkt;
    logic [31:0] w_word;
    exp_pkt_s    e;
    n_pkt = 0;
    for (int i = first; i <= last; i++) begin
      if (test_field(i, col_kind_lp) == 32'h1) n_pkt++;
    end
    for (int i = first; i <= last; i++) begin
      port   = int'(test_field(i, col_port_lp));
      w_word = test_field(i, col_w_lp);
      if (port >= num_ports_lp) abort_run($sformatf("test line %0d names a bad port", i));
      req[port].v    = 1'b1;
      req[port].w    = w_word[0];
      req[port].eva  = test_field(i, col_eva_lp);
      req[port].data = test_field(i, col_data_lp);
      tgo_x       = x_cord_width_gp'(test_field(i, col_tgo_x_lp)); // levels, group wide
      tgo_y       = y_cord_width_gp'(test_field(i, col_tgo_y_lp));
      dram_enable = test_field(i, col_dram_lp) != 32'h0;
      strobe_cycle[port] = cycle_cnt;
      pkt_lines[port]    = n_pkt;
      if (test_field(i, col_kind_lp) == 32'h1) begin
        e.w      = w_word[0];
        e.data   = test_field(i, col_data_lp);
        e.x_cord = x_cord_width_gp'(test_field(i, col_x_lp));
        e.y_cord = y_cord_width_gp'(test_field(i, col_y_lp));
        e.epa    = epa_width_gp'(test_field(i, col_epa_lp));
        exp_q[port].push_back(e);
      end else begin
        err_exp[port]++; // bad eva, pulse only
      end
    end
    @(posedge clk);
    #2;
    for (int p = 0; p < num_ports_lp; p++) req[p].v = 1'b0;
    // good requests go busy right after the strobe edge, bad ones never do
    for (int i = first; i <= last; i++) begin
      port = int'(test_field(i, col_port_lp));
      check_value($sformatf("busy_o[%0d]", port), 32'(busy[port]),
                  32'(test_field(i, col_kind_lp) == 32'h1));
    end
    while (busy != '0) begin
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int first;
    int last;
    int gap;
    int leftover;
    void'($urandom(32'h83371394));
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = '0;
    tgo_x       = '0;
    tgo_y       = '0;
    dram_enable = 1'b0;
    rr_ptr      = 0;
    for (int p = 0; p < num_ports_lp; p++) begin
      err_exp[p]      = 0;
      strobe_cycle[p] = 0;
      pkt_lines[p]    = 0;
    end
    $readmemh("testbench/endpoint_tests.txt", test_mem);
    num_lines = 0;
    while (num_lines < max_lines_lp && test_field(num_lines, col_group_lp) != 32'hff)
      num_lines++;
    if (num_lines == max_lines_lp) abort_run("test file has no end line");
    timeout_cycles = 40 * num_lines + reset_cycles_lp;
    repeat (reset_cycles_lp) @(posedge clk);
    #2;
    rst_n = 1'b1;
    first = 0;
    while (first < num_lines) begin
      last = first;
      while (last + 1 < num_lines &&
             test_field(last + 1, col_group_lp) == test_field(first, col_group_lp))
        last++;
      run_group(first, last);
      gap = 1 + int'($urandom % 4); // at least one idle cycle keeps err pulses apart
      repeat (gap) begin
        @(posedge clk);
        #2;
      end
      first = last + 1;
    end
    repeat (4) @(posedge clk);
    leftover = 0;
    for (int p = 0; p < num_ports_lp; p++) leftover += exp_q[p].size() + err_exp[p];
    if (leftover != 0) begin
      abort_run($sformatf("%0d expected packets or error pulses never arrived", leftover));
    end else begin
      $display("No errors");
      $finish;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_cycles > 0 && cycle_cnt > timeout_cycles)
      abort_run($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
  end

  // outputs settle well before the falling edge
  always @(negedge clk) begin : watch_outputs
    int       exp_src;
    int       lat;
    exp_pkt_s e;
    if (rst_n) begin
      for (int p = 0; p < num_ports_lp; p++) begin
        if (err[p]) begin
          if (err_exp[p] == 0) begin
            abort_run($sformatf("err_o[%0d] pulsed with no bad request outstanding", p));
          end else begin
            check_value($sformatf("err_o[%0d] latency", p), cycle_cnt - strobe_cycle[p], 1);
            err_exp[p]--;
          end
        end
      end
      if (pkt_v) begin
        exp_src = -1;
        // next winner is the first owed port at or after the pointer
        for (int i = 0; i < num_ports_lp; i++) begin
          if (exp_src < 0 && exp_q[(rr_ptr + i) % num_ports_lp].size() > 0)
            exp_src = (rr_ptr + i) % num_ports_lp;
        end
        if (exp_src < 0) begin
          abort_run($sformatf("unexpected packet from port %0d", pkt.src_id));
        end else begin
          check_value("pkt_o.src_id", 32'(pkt.src_id), 32'(exp_src));
          e = exp_q[exp_src].pop_front();
          check_value("pkt_o.w", 32'(pkt.w), 32'(e.w));
          check_value("pkt_o.data", pkt.data, e.data);
          check_value("pkt_o.npa.x_cord", 32'(pkt.npa.x_cord), 32'(e.x_cord));
          check_value("pkt_o.npa.y_cord", 32'(pkt.npa.y_cord), 32'(e.y_cord));
          check_value("pkt_o.npa.epa", 32'(pkt.npa.epa), 32'(e.epa));
          // busy drops on the same edge that launches the packet
          check_value($sformatf("busy_o[%0d]", exp_src), 32'(busy[exp_src]), 0);
          lat = cycle_cnt - strobe_cycle[exp_src];
          if (pkt_lines[exp_src] == 1)
            check_value("pkt_o latency", lat, 2); // uncontested, two edges
          else
            check_value("pkt_o latency in range", 32'(lat >= 2 && lat <= num_ports_lp + 1), 1);
          rr_ptr = (exp_src + 1) % num_ports_lp;
        end
      end
    end
  end

endmodule

// ==== testbench/endpoint_assertions.sv ====
`timescale 1ns/1ps

module endpoint_assertions
  import manycore_net_pkg::*;
#(
  parameter int num_ports_p = 3
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic [num_ports_p-1:0] busy_o,
  input logic [num_ports_p-1:0] err_o,
  input logic                   pkt_v_o,
  input net_packet_s            pkt_o
);

  // injection bus quiet while held in reset
  reset_quiet_a: assert property (@(posedge clk_i) !rst_n_i |-> !pkt_v_o)
    else $error("pkt_v_o high during reset");

  src_id_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_o |-> (int'(pkt_o.src_id) < num_ports_p))
    else $error("pkt_o.src_id %0d out of range", pkt_o.src_id);

  for (genvar p = 0; p < num_ports_p; p++) begin : g_port_chk
    // a bad eva never makes the port pending
    err_not_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(err_o[p] && busy_o[p]))
      else $error("err_o and busy_o both high on port %0d", p);

    err_single_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      err_o[p] |=> !err_o[p])
      else $error("err_o longer than one cycle on port %0d", p);
  end

endmodule

bind manycore_endpoint_top endpoint_assertions #(.num_ports_p(num_ports_p)) u_assertions (
  .clk_i  (clk_i),
  .rst_n_i(rst_n_i),
  .busy_o (busy_o),
  .err_o  (err_o),
  .pkt_v_o(pkt_v_o),
  .pkt_o  (pkt_o)
);

// ==== hw/manycore_endpoint_top.sv ====
`timescale 1ns/1ps

module manycore_endpoint_top
  import manycore_addr_pkg::*;
  import manycore_net_pkg::*;
#(
  parameter int num_ports_p                  = 3,
  parameter int num_tiles_x_p                = 4,   // 2x this many vcaches
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_sets_p                = 64,
  parameter int vcache_size_p                = 1024
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  req_s [num_ports_p-1:0]     req_i,
  input  logic [x_cord_width_gp-1:0] tgo_x_i,       // shared by all ports
  input  logic [y_cord_width_gp-1:0] tgo_y_i,
  input  logic                       dram_enable_i,
  output logic [num_ports_p-1:0]     busy_o,
  output logic [num_ports_p-1:0]     err_o,
  output logic                       pkt_v_o,
  output net_packet_s                pkt_o
);

  logic [num_ports_p-1:0]        pending;
  logic [num_ports_p-1:0]        grant;
  net_packet_s [num_ports_p-1:0] port_pkt;

  // one translating port per requester
  for (genvar p = 0; p < num_ports_p; p++) begin : g_port
    endpoint_req_port #(
      .port_id_p                   (p),
      .num_tiles_x_p               (num_tiles_x_p),
      .vcache_block_size_in_words_p(vcache_block_size_in_words_p),
      .vcache_size_p               (vcache_size_p),
      .vcache_sets_p               (vcache_sets_p)
    ) u_port (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i[p]),
      .tgo_x_i      (tgo_x_i),
      .tgo_y_i      (tgo_y_i),
      .dram_enable_i(dram_enable_i),
      .grant_i      (grant[p]),
      .pending_o    (pending[p]),
      .pkt_o        (port_pkt[p]),
      .busy_o       (busy_o[p]),
      .err_o        (err_o[p])
    );
  end

  net_inject_arbiter #(.num_ports_p(num_ports_p)) u_arb (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .pending_i(pending),
    .pkt_i    (port_pkt),
    .grant_o  (grant),
    .pkt_v_o  (pkt_v_o),
    .pkt_o    (pkt_o)   // registered, one cycle pulse
  );

endmodule

// ==== hw/net_inject_arbiter.sv ====
`timescale 1ns/1ps

module net_inject_arbiter
  import manycore_net_pkg::*;
#(
  parameter int num_ports_p = 3,
  localparam int ptr_width_lp = (num_ports_p > 1) ? $clog2(num_ports_p) : 1
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [num_ports_p-1:0]        pending_i,
  input  net_packet_s [num_ports_p-1:0] pkt_i,
  output logic [num_ports_p-1:0]        grant_o,   // one-hot, combinational
  output logic                          pkt_v_o,
  output net_packet_s                   pkt_o
);

  logic [ptr_width_lp-1:0] ptr_q;   // highest priority port this cycle
  logic [ptr_width_lp-1:0] win;
  logic                    found;
  logic                    pkt_v_q;
  net_packet_s             pkt_q;

  // search from ptr_q upwards, wrapping
  always_comb begin
    int unsigned idx;
    found   = 1'b0;
    win     = '0;
    grant_o = '0;
    for (int i = 0; i < num_ports_p; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= num_ports_p) idx = idx - num_ports_p;
      if (!found && pending_i[idx]) begin
        found = 1'b1;
        win   = ptr_width_lp'(idx);
      end
    end
    if (found) grant_o[win] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q   <= '0;
      pkt_v_q <= 1'b0;
    end else begin
      pkt_v_q <= found; // one packet per cycle at most
      if (found) begin
        // next search starts just after the winner
        ptr_q <= (win == ptr_width_lp'(num_ports_p - 1)) ? '0 : win + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (found) pkt_q <= pkt_i[win];
  end

  assign pkt_v_o = pkt_v_q;
  assign pkt_o   = pkt_q;

endmodule

// ==== hw/endpoint_req_port.sv ====
`timescale 1ns/1ps

module endpoint_req_port
  import manycore_addr_pkg::*;
  import manycore_net_pkg::*;
#(
  parameter int port_id_p                    = 0,
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 1024,
  parameter int vcache_sets_p                = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  req_s                       req_i,
  input  logic [x_cord_width_gp-1:0] tgo_x_i,
  input  logic [y_cord_width_gp-1:0] tgo_y_i,
  input  logic                       dram_enable_i,
  input  logic                       grant_i,   // same-cycle grant from arbiter
  output logic                       pending_o,
  output net_packet_s                pkt_o,
  output logic                       busy_o,
  output logic                       err_o      // one cycle, bad eva
);

  npa_s        npa;
  logic        invalid;
  logic        accept;
  logic        pending_q;
  logic        err_q;
  net_packet_s pkt_q;

  eva_to_npa #(
    .num_tiles_x_p               (num_tiles_x_p),
    .vcache_block_size_in_words_p(vcache_block_size_in_words_p),
    .vcache_size_p               (vcache_size_p),
    .vcache_sets_p               (vcache_sets_p)
  ) u_xlate (
    .eva_i            (req_i.eva),
    .tgo_x_i          (tgo_x_i),
    .tgo_y_i          (tgo_y_i),
    .dram_enable_i    (dram_enable_i),
    .npa_o            (npa),
    .is_invalid_addr_o(invalid)
  );

  assign accept = req_i.v & ~pending_q; // strobe while busy is dropped

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      err_q <= accept & invalid; // self clearing pulse
      if (accept && !invalid) pending_q <= 1'b1;
      else if (grant_i)       pending_q <= 1'b0;
    end
  end

  // packet payload, only meaningful while pending
  always_ff @(posedge clk_i) begin
    if (accept && !invalid) begin
      pkt_q.src_id <= src_id_width_gp'(port_id_p);
      pkt_q.w      <= req_i.w;
      pkt_q.data   <= req_i.data;
      pkt_q.npa    <= npa;
    end
  end

  assign pending_o = pending_q;
  assign busy_o    = pending_q; // busy until granted
  assign err_o     = err_q;
  assign pkt_o     = pkt_q;

endmodule

// ==== hw/eva_to_npa.sv ====
`timescale 1ns/1ps

module eva_to_npa
  import manycore_addr_pkg::*;
#(
  parameter int num_tiles_x_p                = 4,
  parameter int vcache_block_size_in_words_p = 8,
  parameter int vcache_size_p                = 1024, // words per vcache
  parameter int vcache_sets_p                = 64
) (
  input  eva_u                       eva_i,
  input  logic [x_cord_width_gp-1:0] tgo_x_i,       // tile-group origin
  input  logic [y_cord_width_gp-1:0] tgo_y_i,
  input  logic                       dram_enable_i, // 1 = striped dram
  output npa_s                       npa_o,
  output logic                       is_invalid_addr_o
);

  localparam int word_off_lp       = $clog2(vcache_block_size_in_words_p);
  localparam int lg_vcache_size_lp = $clog2(vcache_size_p);
  localparam int num_banks_lp      = 2 * num_tiles_x_p; // top row plus bottom row
  localparam int lg_banks_lp       = $clog2(num_banks_lp);
  localparam int lg_sets_lp        = $clog2(vcache_sets_p);

  logic is_dram, is_global, is_tile_group, is_shared;

  logic [eva_width_gp-1:0] dram_block;
  logic [lg_banks_lp-1:0]  hash_bank;
  logic [lg_sets_lp-1:0]   hash_index;
  logic [lg_banks_lp-1:0]  bm_bank; // block mapped bank, dram mode off

  // class decode, one word viewed several ways
  assign is_dram       = eva_i.raw[eva_width_gp-1];
  assign is_global     = (eva_i.global_addr.remote == 2'b01);
  assign is_tile_group = (eva_i.tile_group_addr.remote == 3'b001);
  assign is_shared     = (eva_i.shared_addr.remote == 5'b00001);

  assign is_invalid_addr_o = ~(is_dram | is_global | is_tile_group | is_shared);

  // block number = eva[30:2+word_off], bit 31 is the dram tag
  assign dram_block = eva_width_gp'(eva_i.raw[eva_width_gp-2:2+word_off_lp]);

  vcache_bank_hash #(
    .num_banks_p  (num_banks_lp),
    .vcache_sets_p(vcache_sets_p)
  ) u_hash (
    .block_i(dram_block),
    .bank_o (hash_bank),
    .index_o(hash_index)
  );

  assign bm_bank = eva_i.raw[2+lg_vcache_size_lp+:lg_banks_lp]; // bits above one vcache

  always_comb begin
    npa_o = '0; // invalid class leaves all zero
    if (is_dram) begin
      if (dram_enable_i) begin
        // top bank bit picks bottom row, low bits pick column
        npa_o.y_cord = hash_bank[lg_banks_lp-1] ? '1 : '0;
        npa_o.x_cord = x_cord_width_gp'(hash_bank[lg_banks_lp-2:0]);
        npa_o.epa    = epa_width_gp'({hash_index, eva_i.raw[2+:word_off_lp]});
      end else if (eva_i.raw[eva_width_gp-2]) begin
        // host memory port
        npa_o.y_cord = y_cord_width_gp'(1);
        npa_o.x_cord = '0;
        npa_o.epa    = {1'b1, eva_i.raw[2+:epa_width_gp-1]};
      end else begin
        // each vcache is a plain block of memory
        npa_o.y_cord = bm_bank[lg_banks_lp-1] ? '1 : '0;
        npa_o.x_cord = x_cord_width_gp'(bm_bank[lg_banks_lp-2:0]);
        npa_o.epa    = epa_width_gp'(eva_i.raw[2+:lg_vcache_size_lp]);
      end
    end else if (is_global) begin
      // coords straight from the eva, upper bits dropped
      npa_o.y_cord = y_cord_width_gp'(eva_i.global_addr.y_cord);
      npa_o.x_cord = x_cord_width_gp'(eva_i.global_addr.x_cord);
      npa_o.epa    = eva_i.global_addr.addr;
    end else if (is_tile_group) begin
      // relative to origin, sum wraps at coord width
      npa_o.y_cord = y_cord_width_gp'(eva_i.tile_group_addr.y_cord + tgo_y_i);
      npa_o.x_cord = x_cord_width_gp'(eva_i.tile_group_addr.x_cord + tgo_x_i);
      npa_o.epa    = eva_i.tile_group_addr.addr;
    end else if (is_shared) begin
      npa_o.y_cord = y_cord_width_gp'(eva_i.shared_addr.y_cord + tgo_y_i);
      npa_o.x_cord = x_cord_width_gp'(eva_i.shared_addr.x_cord + tgo_x_i);
      // shared words live above dmem base
      npa_o.epa    = epa_width_gp'({eva_i.shared_addr.addr, eva_i.shared_addr.stripe}
                                   + dmem_start_gp);
    end
  end

endmodule

// ==== hw/vcache_bank_hash.sv ====
`timescale 1ns/1ps

module vcache_bank_hash
  import manycore_addr_pkg::*;
#(
  parameter int num_banks_p   = 8,  // power of two
  parameter int vcache_sets_p = 64,
  localparam int lg_banks_lp  = $clog2(num_banks_p),
  localparam int lg_sets_lp   = $clog2(vcache_sets_p)
) (
  input  logic [eva_width_gp-1:0] block_i, // dram block number, zero extended
  output logic [lg_banks_lp-1:0]  bank_o,
  output logic [lg_sets_lp-1:0]   index_o
);

  logic [lg_banks_lp-1:0] bank_lo; // low field of the block number
  logic [lg_banks_lp-1:0] bank_hi; // next field up
  logic [eva_width_gp-1:0] block_shifted;

  assign bank_lo = block_i[0+:lg_banks_lp];
  assign bank_hi = block_i[lg_banks_lp+:lg_banks_lp];

  // xor folding spreads power-of-two strides over all banks
  assign bank_o = bank_lo ^ bank_hi;

  // bank bits stripped, rest of the block picks the set
  assign block_shifted = block_i >> lg_banks_lp;
  assign index_o       = block_shifted[lg_sets_lp-1:0]; // upper bits become tag

endmodule

// ==== hw/manycore_net_pkg.sv ====
package manycore_net_pkg;

  import manycore_addr_pkg::*;

  parameter int data_width_gp   = 32;
  parameter int src_id_width_gp = 4; // up to 16 requesters

  // one requester's remote load or store
  typedef struct packed {
    logic                     v;    // single cycle strobe
    logic                     w;    // 1 = store
    eva_u                     eva;
    logic [data_width_gp-1:0] data; // store data, don't care on loads
  } req_s;

  // packet as placed on the injection bus
  typedef struct packed {
    logic [src_id_width_gp-1:0] src_id;
    logic                       w;
    logic [data_width_gp-1:0]   data;
    npa_s                       npa; // destination
  } net_packet_s;

endpackage

// ==== hw/manycore_addr_pkg.sv ====
package manycore_addr_pkg;

  // byte address as seen by the requesters
  parameter int eva_width_gp = 32;

  // mesh coordinates, rows 0 and 7 hold the vcaches
  parameter int x_cord_width_gp = 4;
  parameter int y_cord_width_gp = 3;

  parameter int epa_width_gp = 18; // endpoint word address

  // fixed 4x4 tile group, 8 word stripe
  parameter int tg_cord_width_gp = 2;
  parameter int stripe_width_gp  = 3;

  // word address of dmem[0] inside a tile
  parameter logic [epa_width_gp-1:0] dmem_start_gp = 18'h1000;

  // global eva, remote == 2'b01
  typedef struct packed {
    logic [1:0]              remote; // 31:30
    logic [5:0]              y_cord; // 29:24
    logic [5:0]              x_cord; // 23:18
    logic [epa_width_gp-1:0] addr;   // 17:0
  } eva_global_s;

  // tile-group eva, remote == 3'b001
  typedef struct packed {
    logic [2:0]              remote; // 31:29
    logic [4:0]              y_cord; // 28:24
    logic [5:0]              x_cord; // 23:18
    logic [epa_width_gp-1:0] addr;   // 17:0
  } eva_tile_group_s;

  // tile-group shared eva, remote == 5'b00001
  // words striped across the group, stripe sits below the tile coords
  typedef struct packed {
    logic [4:0]                  remote;   // 31:27
    logic [epa_width_gp-1:0]     addr;     // 26:9
    logic [tg_cord_width_gp-1:0] y_cord;   // 8:7
    logic [tg_cord_width_gp-1:0] x_cord;   // 6:5
    logic [stripe_width_gp-1:0]  stripe;   // 4:2
    logic [1:0]                  byte_off; // ignored, word access
  } eva_shared_s;

  // one eva word, read through whichever view matches its class
  typedef union packed {
    logic [eva_width_gp-1:0] raw;
    eva_global_s             global_addr;
    eva_tile_group_s         tile_group_addr;
    eva_shared_s             shared_addr;
  } eva_u;

  // network physical address
  typedef struct packed {
    logic [x_cord_width_gp-1:0] x_cord;
    logic [y_cord_width_gp-1:0] y_cord;
    logic [epa_width_gp-1:0]    epa;
  } npa_s;

endpackage
